//--- verilog.f
+incdir+.
peakPkg.sv
peakBankIf.sv
max4Signed.sv
peakSearch.sv
wbPeakRegs.sv
peakFinderTop.sv
tbPeakFinder.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tbPeakFinder
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tbPeakFinder.sv
`timescale 1ns/100ps
`include "peakFinder_consts.svh"

module tbPeakFinder;

   localparam int ACK_TIMEOUT   = 16;   // cycles allowed for one bus ack
   localparam int POLL_LIMIT    = 40;   // status reads before giving up on done
   localparam int SEARCH_ROUNDS = 40;

   logic                     clk;
   logic                     rst;
   logic                     wbCyc;
   logic                     wbStb;
   logic                     wbWe;
   logic [`WB_ADR_WIDTH-1:0] wbAdr;
   logic [`WB_DAT_WIDTH-1:0] wbDatIn;
   logic [`WB_DAT_WIDTH-1:0] wbDatOut;
   logic                     wbAck;

   integer seed;
   int     errCount;
   int     checkCount;
   int     testErrStart;
   logic   timedOut;
   logic signed [`SAMPLE_WIDTH-1:0] shadow [`NUM_SAMPLES];   // model copy of the bank

   peakFinderTop dut_i
   (
      .clk     (clk),
      .rst     (rst),
      .wbCyc   (wbCyc),
      .wbStb   (wbStb),
      .wbWe    (wbWe),
      .wbAdr   (wbAdr),
      .wbDatIn (wbDatIn),
      .wbDatOut(wbDatOut),
      .wbAck   (wbAck)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic finishRun();
      $display("summary: %0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0 && !timedOut)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   endtask

   // later bus cycles and checks are skipped once set
   task automatic reportTimeout(input string what);
      if (!timedOut)
         $display("timeout at %0t ns: %s never completed", $time, what);
      timedOut = 1'b1;
   endtask

   task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (timedOut)
         return;
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("ERR at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic reportTest(input string name);
      if (timedOut)
         $display("test %s: stopped by timeout", name);
      else if (errCount == testErrStart)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errCount - testErrStart);
      testErrStart = errCount;
   endtask

   // entered and left on a falling edge
   task automatic busCycle(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
                           input logic [31:0] din, output logic [31:0] dout);
      int waitCount;
      if (timedOut)
         return;
      wbCyc     = 1'b1;
      wbStb     = 1'b1;
      wbWe      = we;
      wbAdr     = adr;
      wbDatIn   = din;
      waitCount = 0;
      @(negedge clk);
      while (!wbAck && waitCount < ACK_TIMEOUT)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (!wbAck)
         reportTimeout("wishbone ack");
      dout  = wbDatOut;   // stable in the middle of the ack cycle
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
   endtask

   task automatic wbWrite(input logic [`WB_ADR_WIDTH-1:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      busCycle(1'b1, adr, data, unused);
   endtask

   task automatic wbRead(input logic [`WB_ADR_WIDTH-1:0] adr, output logic [31:0] data);
      busCycle(1'b0, adr, 32'h0, data);
   endtask

   task automatic waitDone(output logic [31:0] status);
      int polls;
      polls = 0;
      wbRead(`ADR_STATUS, status);
      while (!status[1] && polls < POLL_LIMIT && !timedOut)
      begin
         wbRead(`ADR_STATUS, status);
         polls++;
      end
      if (!status[1])
         reportTimeout("peak search");
   endtask

   // linear scan where the later index wins a tie
   function automatic logic [31:0] expectedResult();
      int bestIdx;
      bestIdx = 0;
      for (int i = 1; i < `NUM_SAMPLES; i++)
         if (shadow[i] >= shadow[bestIdx])
            bestIdx = i;
      return (32'(bestIdx) << 16) | {20'h0, shadow[bestIdx]};
   endfunction

   function automatic logic [31:0] signExtend(input int idx);
      return {{20{shadow[idx][`SAMPLE_WIDTH-1]}}, shadow[idx]};
   endfunction

   task automatic writeSample(input int idx, input logic [31:0] data);
      wbWrite(`WB_ADR_WIDTH'(idx), data);
      shadow[idx] = data[`SAMPLE_WIDTH-1:0];
   endtask

   task automatic writeRandomBank();
      logic [31:0] data;
      for (int i = 0; i < `NUM_SAMPLES; i++)
      begin
         data = $random(seed);
         writeSample(i, data);
      end
   endtask

   // kind 0 all negative, 1 extremes only, 2 narrow range with many ties, else fill
   task automatic writePatternBank(input int kind, input logic [11:0] fillVal);
      logic [31:0] r;
      logic [11:0] s;
      for (int i = 0; i < `NUM_SAMPLES; i++)
      begin
         r = $random(seed);
         case (kind)
            0:       s = {1'b1, r[10:0]};
            1:       s = r[0] ? 12'h7FF : 12'h800;
            2:       s = {{10{r[1]}}, r[1:0]};   // -2 to 1
            default: s = fillVal;
         endcase
         writeSample(i, {r[31:12], s});   // upper bits must be ignored
      end
   endtask

   task automatic searchAndCheck(input string what);
      logic [31:0] status;
      logic [31:0] result;
      wbWrite(`ADR_CTRL, 32'h1);
      waitDone(status);
      checkWord({what, " status"}, status, 32'h2);   // done set and busy clear
      wbRead(`ADR_RESULT, result);
      checkWord({what, " result"}, result, expectedResult());
   endtask

   initial
   begin
      logic [31:0] rd;
      logic [31:0] oldWord;
      seed         = 80;
      errCount     = 0;
      checkCount   = 0;
      testErrStart = 0;
      timedOut     = 1'b0;
      rst          = 1'b1;
      wbCyc        = 1'b0;
      wbStb        = 1'b0;
      wbWe         = 1'b0;
      wbAdr        = '0;
      wbDatIn      = '0;
      for (int i = 0; i < `NUM_SAMPLES; i++)
         shadow[i] = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // whole address space is zero after reset
      for (int a = 0; a < 32; a++)
      begin
         wbRead(`WB_ADR_WIDTH'(a), rd);
         checkWord($sformatf("address %0d after reset", a), rd, 32'h0);
      end
      reportTest("reset values");

      writeRandomBank();
      for (int i = 0; i < `NUM_SAMPLES; i++)
      begin
         wbRead(`WB_ADR_WIDTH'(i), rd);
         checkWord($sformatf("sample %0d", i), rd, signExtend(i));
      end
      reportTest("sample readback");

      for (int r = 0; r < SEARCH_ROUNDS; r++)
      begin
         writeRandomBank();
         searchAndCheck($sformatf("random round %0d", r));
      end
      reportTest("random peak search");

      for (int k = 0; k < 6; k++)
      begin
         writePatternBank(k / 2, 12'h0);
         searchAndCheck($sformatf("pattern %0d", k));
      end
      writePatternBank(3, 12'h7FF);
      searchAndCheck("all max positive");
      writePatternBank(3, 12'h800);
      searchAndCheck("all max negative");
      writePatternBank(3, 12'h000);
      searchAndCheck("all zero");
      reportTest("sign and tie cases");

      // sample write lands while the bank is frozen
      writeRandomBank();
      oldWord = signExtend(5);
      wbWrite(`ADR_CTRL, 32'h1);
      wbWrite(5'd5, ~oldWord);
      waitDone(rd);
      checkWord("lockout status", rd, 32'h2);
      wbRead(5'd5, rd);
      checkWord("locked sample", rd, oldWord);
      wbRead(`ADR_RESULT, rd);
      checkWord("locked result", rd, expectedResult());
      wbWrite(`ADR_CTRL, 32'h1);
      wbWrite(`ADR_CTRL, 32'h1);   // second start during busy
      waitDone(rd);
      checkWord("status after ignored start", rd, 32'h2);
      for (int k = 0; k < 3; k++)
      begin
         wbRead(`ADR_STATUS, rd);
         checkWord("sticky done", rd, 32'h2);
      end
      wbRead(`ADR_RESULT, rd);
      checkWord("result after ignored start", rd, expectedResult());
      writeSample(9, 32'h7FF);
      wbWrite(`ADR_CTRL, 32'h1);
      wbRead(`ADR_STATUS, rd);
      checkWord("done cleared by start", rd & 32'h2, 32'h0);
      waitDone(rd);
      wbRead(`ADR_RESULT, rd);
      checkWord("result after new start", rd, expectedResult());
      reportTest("lockout and sticky done");

      finishRun();
   end

endmodule

//--- peakFinderTop.sv
`timescale 1ns/100ps
`include "peakFinder_consts.svh"

module peakFinderTop
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     wbCyc,
   input  logic                     wbStb,
   input  logic                     wbWe,
   input  logic [`WB_ADR_WIDTH-1:0] wbAdr,
   input  logic [`WB_DAT_WIDTH-1:0] wbDatIn,
   output logic [`WB_DAT_WIDTH-1:0] wbDatOut,
   output logic                     wbAck
);

   // bank, start and result between the bus side and the search engine
   peakBankIf bankIf_i ();

   // bus side, owns the sample bank
   wbPeakRegs regs_i
   (
      .clk     (clk),
      .rst     (rst),
      .wbCyc   (wbCyc),
      .wbStb   (wbStb),
      .wbWe    (wbWe),
      .wbAdr   (wbAdr),
      .wbDatIn (wbDatIn),
      .wbDatOut(wbDatOut),
      .wbAck   (wbAck),
      .bank    (bankIf_i.regs)
   );

   // three-cycle comparator tree
   peakSearch search_i
   (
      .clk (clk),
      .rst (rst),
      .bank(bankIf_i.search)
   );

endmodule

//--- wbPeakRegs.sv
`timescale 1ns/100ps
`include "peakFinder_consts.svh"

module wbPeakRegs
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     wbCyc,
   input  logic                     wbStb,
   input  logic                     wbWe,
   input  logic [`WB_ADR_WIDTH-1:0] wbAdr,
   input  logic [`WB_DAT_WIDTH-1:0] wbDatIn,
   output logic [`WB_DAT_WIDTH-1:0] wbDatOut,
   output logic                     wbAck,
   peakBankIf.regs                  bank
);
   import peakPkg::*;

   localparam int SEL_WIDTH = $clog2(`NUM_SAMPLES);
   localparam int IDX_LSB   = 16;   // index field of the result word

   sampleBank_t samples;
   logic        access;        // new bus cycle acked on this edge
   logic        writeAccess;
   logic        sampleAdr;
   logic        locked;        // bank frozen for a search
   logic        startAccept;
   logic        startReg;
   logic        doneFlag;      // sticky done
   sample_t     resultVal;
   index_t      resultIdx;
   logic [SEL_WIDTH-1:0] sampleSel;

   assign access      = wbCyc && wbStb && !wbAck;
   assign writeAccess = access && wbWe;
   assign sampleAdr   = (wbAdr < `WB_ADR_WIDTH'(`NUM_SAMPLES));
   assign sampleSel   = wbAdr[SEL_WIDTH-1:0];
   assign locked      = bank.busy;
   assign startAccept = writeAccess && (wbAdr == `ADR_CTRL) && wbDatIn[0] && !locked;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wbAck     <= 1'b0;
         startReg  <= 1'b0;
         doneFlag  <= 1'b0;
         resultVal <= '0;
         resultIdx <= '0;
         for (int i = 0; i < `NUM_SAMPLES; i++)
         begin
            samples[i] <= '0;
         end
      end
      else
      begin
         wbAck    <= access;     // write lands on the ack edge
         startReg <= startAccept;
         if (startAccept)
         begin
            doneFlag <= 1'b0;
         end
         else if (bank.done)
         begin
            doneFlag <= 1'b1;
         end
         if (bank.done)
         begin
            resultVal <= bank.peakValue;
            resultIdx <= bank.peakIndex;
         end
         if (writeAccess && sampleAdr && !locked)   // dropped during a search
         begin
            samples[sampleSel] <= sample_t'(wbDatIn[`SAMPLE_WIDTH-1:0]);
         end
      end
   end

   // read data follows the address while ack is high
   always_comb
   begin
      wbDatOut = '0;
      if (sampleAdr)
      begin
         wbDatOut = `WB_DAT_WIDTH'(samples[sampleSel]);   // signed cast extends the sign
      end
      else
      begin
         case (wbAdr)
            `ADR_STATUS:
            begin
               wbDatOut[0] = bank.busy;
               wbDatOut[1] = doneFlag || bank.done;   // visible on the done cycle itself
            end
            `ADR_RESULT:
            begin
               wbDatOut[`SAMPLE_WIDTH-1:0]         = resultVal;
               wbDatOut[IDX_LSB +: `INDEX_WIDTH]   = resultIdx;
            end
            default:
            begin
               wbDatOut = '0;   // control and unmapped read as zero
            end
         endcase
      end
   end

   assign bank.samples = samples;
   assign bank.start   = startReg;

endmodule

//--- peakSearch.sv
`timescale 1ns/100ps
`include "peakFinder_consts.svh"

module peakSearch
(
   input logic      clk,
   input logic      rst,
   peakBankIf.search bank
);
   import peakPkg::*;

   localparam int GROUP_SIZE = 4;
   localparam int NUM_GROUPS = `NUM_SAMPLES / GROUP_SIZE;

   sample_t    grpMax [NUM_GROUPS];     // stage 1 winners
   index_t     grpIndex [NUM_GROUPS];   // their absolute positions
   sample_t    s2Max;
   index_t     s2Index;                 // winning group number
   logic [1:0] stageVld;                // bit 0 stage 1, bit 1 stage 2
   logic       doneReg;
   sample_t    peakValueReg;
   index_t     peakIndexReg;

   // stage 1, one comparator per group of four samples
   for (genvar g = 0; g < NUM_GROUPS; g++)
   begin : gGroup
      max4Signed
      #(
         .indexOffset(g * GROUP_SIZE)
      )
      grpCmp_i
      (
         .clk   (clk),
         .rst   (rst),
         .a     (bank.samples[g * GROUP_SIZE]),
         .b     (bank.samples[g * GROUP_SIZE + 1]),
         .c     (bank.samples[g * GROUP_SIZE + 2]),
         .d     (bank.samples[g * GROUP_SIZE + 3]),
         .index (grpIndex[g]),
         .maxVal(grpMax[g])
      );
   end

   // stage 2 picks the best group
   max4Signed
   #(
      .indexOffset(0)
   )
   finalCmp_i
   (
      .clk   (clk),
      .rst   (rst),
      .a     (grpMax[0]),
      .b     (grpMax[1]),
      .c     (grpMax[2]),
      .d     (grpMax[3]),
      .index (s2Index),
      .maxVal(s2Max)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stageVld     <= '0;
         doneReg      <= 1'b0;
         peakValueReg <= '0;
         peakIndexReg <= '0;
      end
      else
      begin
         stageVld <= {stageVld[0], bank.start};
         doneReg  <= stageVld[1];
         if (stageVld[1])
         begin
            peakValueReg <= s2Max;
            peakIndexReg <= grpIndex[s2Index[1:0]];   // bank is frozen, stage 1 still valid
         end
      end
   end

   assign bank.busy      = |stageVld;   // drops on the edge that raises done
   assign bank.done      = doneReg;
   assign bank.peakValue = peakValueReg;
   assign bank.peakIndex = peakIndexReg;

endmodule

//--- max4Signed.sv
`timescale 1ns/100ps

module max4Signed
#(
   parameter int indexOffset = 0
)
(
   input  logic             clk,
   input  logic             rst,
   input  peakPkg::sample_t a,
   input  peakPkg::sample_t b,
   input  peakPkg::sample_t c,
   input  peakPkg::sample_t d,
   output peakPkg::index_t  index,
   output peakPkg::sample_t maxVal
);
   import peakPkg::*;

   localparam int SIGN_BIT = $bits(sample_t) - 1;

   logic       selAb;      // b beats a
   logic       selCd;      // d beats c
   logic       selFinal;   // cd winner beats ab winner
   sample_t    winAb;
   sample_t    winCd;
   sample_t    localMax;
   logic [1:0] localPos;

   // true when y is at least as large as x, so the second input takes a tie
   function automatic logic secondWins(input sample_t x, input sample_t y);
      logic sameSign;
      sameSign = (x[SIGN_BIT] == y[SIGN_BIT]);
      if (sameSign)
      begin
         return ($unsigned(y) >= $unsigned(x));   // magnitude order holds within one sign
      end
      else
      begin
         return !y[SIGN_BIT];                     // non-negative side wins
      end
   endfunction

   always_comb
   begin
      selAb    = secondWins(a, b);
      selCd    = secondWins(c, d);
      winAb    = selAb ? b : a;
      winCd    = selCd ? d : c;
      selFinal = secondWins(winAb, winCd);
      if (selFinal)
      begin
         localPos = {1'b1, selCd};   // c or d
         localMax = winCd;
      end
      else
      begin
         localPos = {1'b0, selAb};   // a or b
         localMax = winAb;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         index  <= '0;
         maxVal <= '0;
      end
      else
      begin
         index  <= index_t'(localPos) + index_t'(indexOffset);   // absolute position
         maxVal <= localMax;
      end
   end

endmodule

//--- peakBankIf.sv
`timescale 1ns/100ps

interface peakBankIf;
   import peakPkg::*;

   sampleBank_t samples;       // bank contents, stable while busy
   logic        start;         // one-cycle search request
   logic        busy;          // search in flight
   logic        done;          // one-cycle result strobe
   sample_t     peakValue;
   index_t      peakIndex;

   modport regs
   (
      output samples,
      output start,
      input  busy,
      input  done,
      input  peakValue,
      input  peakIndex
   );

   modport search
   (
      input  samples,
      input  start,
      output busy,
      output done,
      output peakValue,
      output peakIndex
   );

endinterface

//--- peakPkg.sv
`include "peakFinder_consts.svh"

package peakPkg;

   // one signed correlation sample
   typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

   // position of a sample inside the block
   typedef logic [`INDEX_WIDTH-1:0] index_t;

   // whole block as seen by the search engine
   typedef sample_t sampleBank_t [`NUM_SAMPLES];

endpackage

//--- peakFinder_consts.svh
`ifndef PEAKFINDER_CONSTS_SVH
`define PEAKFINDER_CONSTS_SVH

// sample format and block size
`define SAMPLE_WIDTH 12
`define NUM_SAMPLES  16
`define INDEX_WIDTH  5

// wishbone word address and data widths
`define WB_ADR_WIDTH 5
`define WB_DAT_WIDTH 32

// register word addresses above the sample bank
`define ADR_CTRL   5'd16
`define ADR_STATUS 5'd17
`define ADR_RESULT 5'd18

`endif
